/* design/compact_pkg.sv */
//////////////////////////////////////////////////
// word count and word width are fixed at 8 and 64
// queue_depth must be a power of two for pointer wrap
//////////////////////////////////////////////////
`default_nettype none

package compact_pkg;

	// the compactor priority logic is built for exactly eight words
	localparam int num_words = 8;
	localparam int word_w = 64;
	// page queue depth, also the credit count after reset
	localparam int queue_depth = 4;

	typedef logic [word_w-1:0] word_t;
	// msb marks the first word, which is the most significant word
	typedef logic [num_words-1:0] mask_t;
	// word count from 0 to 8
	typedef logic [3:0] count_t;
	// credit count from 0 to queue_depth
	typedef logic [2:0] credit_t;
	// read and write pointers into the page queue
	typedef logic [$clog2(queue_depth)-1:0] qptr_t;

	// input beat, first word in the most significant slot
	typedef struct packed {
		word_t [num_words-1:0] words;
		mask_t mask;
		logic last;
	} beat_t;

	// compactor output, valid words packed toward the most significant end
	typedef struct packed {
		word_t [num_words-1:0] words;
		count_t count;
		logic last;
	} cbeat_t;

	// output page, words from the count onward are don't-care
	typedef struct packed {
		word_t [num_words-1:0] words;
		count_t count;
		logic last;
	} page_t;

endpackage

`default_nettype wire

/* design/word_capture.sv */
//////////////////////////////////////////////////
// four-phase slave, in_beat must hold while in_req is high
// a beat is taken only with two credits free
//////////////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module word_capture (
	input wire logic clk,
	input wire logic arst,
	input wire logic in_req,
	input wire compact_pkg::beat_t in_beat,
	output logic in_ack,
	output logic cap_valid,
	output compact_pkg::beat_t cap_beat,
	input wire compact_pkg::credit_t cr_ret,
	input wire logic pg_done
);

	import compact_pkg::*;

	typedef enum logic {
		idle,
		acked
	} state_t;

	state_t state;
	credit_t credits;
	logic take;
	logic [3:0] credit_sum;

	// a beat that ends a packet can produce two pages, so reserve two slots
	assign take = (state == idle) && in_req && (credits >= credit_t'(2));

	// returned credits from the accumulator and the sender, minus this beat's share
	always_comb begin
		credit_sum = {1'b0, credits} + {1'b0, cr_ret} + {3'b000, pg_done};
		if (take) begin
			credit_sum = credit_sum - 4'd2;
		end
	end

	//////////////////////////////////////////////////
	// handshake FSM and credit counter
	//////////////////////////////////////////////////

	always_ff @(posedge clk or posedge arst) begin
		if (arst) begin
			state <= idle;
			in_ack <= 1'b0;
			cap_valid <= 1'b0;
			credits <= credit_t'(queue_depth);
		end else begin
			credits <= credit_t'(credit_sum);
			// cap_valid is a single cycle strobe that rises with in_ack
			cap_valid <= take;
			case (state)
				idle: begin
					if (take) begin
						in_ack <= 1'b1;
						state <= acked;
					end
				end
				acked: begin
					// master drops req, then ack follows it down
					if (!in_req) begin
						in_ack <= 1'b0;
						state <= idle;
					end
				end
				default: state <= idle;
			endcase
		end
	end

	// the beat is latched on accept and held until the next one
	always_ff @(posedge clk) begin
		if (take) begin
			cap_beat <= in_beat;
		end
	end

	// credits flow back from two stages and must never exceed the queue size
	a_credit_max: assert property (@(posedge clk) disable iff (arst)
		credits <= credit_t'(queue_depth));

	a_beat_stable: assert property (@(posedge clk) disable iff (arst)
		in_req && $past(in_req) |-> $stable(in_beat));

endmodule

`default_nettype wire

/* design/word_compactor.sv */
//////////////////////////////////////////////////
// fixed latency of two cycles and no stall
// output words from the count onward are don't-care
//////////////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module word_compactor (
	input wire logic clk,
	input wire logic arst,
	input wire logic cap_valid,
	input wire compact_pkg::beat_t cap_beat,
	output logic cmp_valid,
	output compact_pkg::cbeat_t cmp_beat
);

	import compact_pkg::*;

	// positions are numbered 0..7 from the first (most significant) word
	count_t [num_words:0] pre_c;

	logic s1_valid;
	logic s1_last;
	count_t s1_count;
	word_t [num_words-1:0] s1_words;
	// number of valid words ahead of each position
	count_t [num_words-1:0] s1_pre;

	word_t [num_words-1:0] sel_w;

	//////////////////////////////////////////////////
	// stage 1 prefix counts
	//////////////////////////////////////////////////

	// running count whose final entry is the number of valid words in the beat
	always_comb begin
		pre_c[0] = '0;
		for (int p = 0; p < num_words; p++) begin
			pre_c[p+1] = pre_c[p] + count_t'(cap_beat.mask[num_words-1-p]);
		end
	end

	always_ff @(posedge clk or posedge arst) begin
		if (arst) begin
			s1_valid <= 1'b0;
		end else begin
			s1_valid <= cap_valid;
		end
	end

	always_ff @(posedge clk) begin
		s1_words <= cap_beat.words;
		s1_last <= cap_beat.last;
		s1_count <= pre_c[num_words];
		for (int p = 0; p < num_words; p++) begin
			s1_pre[p] <= pre_c[p];
		end
	end

	//////////////////////////////////////////////////
	// stage 2 priority select
	//////////////////////////////////////////////////

	// every position whose prefix equals slot j is a candidate for slot j
	// the run of such positions ends with the valid word, so the last match wins
	// and the mask itself is not needed here
	always_comb begin
		for (int j = 0; j < num_words; j++) begin
			// default only matters for slots past the count
			sel_w[num_words-1-j] = s1_words[num_words-1-j];
			for (int p = 0; p < num_words; p++) begin
				if (s1_pre[p] == count_t'(j)) begin
					sel_w[num_words-1-j] = s1_words[num_words-1-p];
				end
			end
		end
	end

	always_ff @(posedge clk or posedge arst) begin
		if (arst) begin
			cmp_valid <= 1'b0;
		end else begin
			cmp_valid <= s1_valid;
		end
	end

	// count and last ride along with the packed words
	always_ff @(posedge clk) begin
		cmp_beat.words <= sel_w;
		cmp_beat.count <= s1_count;
		cmp_beat.last <= s1_last;
	end

endmodule

`default_nettype wire

/* design/page_accumulator.sv */
//////////////////////////////////////////////////
// up to two page writes per beat, relies on upstream credits
// for queue space, there is no stall toward the compactor
//////////////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module page_accumulator (
	input wire logic clk,
	input wire logic arst,
	input wire logic cmp_valid,
	input wire compact_pkg::cbeat_t cmp_beat,
	output logic q_valid,
	output compact_pkg::page_t q_page,
	input wire logic q_pop,
	output compact_pkg::credit_t cr_ret
);

	import compact_pkg::*;

	// residue of 0 to 7 words packed toward the most significant end
	count_t res_cnt;
	word_t [num_words-1:0] res_words;

	// residue plus new words, 0..15
	logic [4:0] total;
	logic full;
	word_t join_w [2*num_words];
	word_t [num_words-1:0] lo_words;
	word_t [num_words-1:0] hi_words;
	page_t pg_a;
	page_t pg_b;
	logic [1:0] n_wr;

	page_t mem [queue_depth];
	qptr_t wr_ptr;
	qptr_t rd_ptr;
	// queue occupancy shares the credit range 0..queue_depth
	credit_t q_cnt;

	//////////////////////////////////////////////////
	// join residue and compacted beat
	//////////////////////////////////////////////////

	always_comb begin
		total = {1'b0, res_cnt} + {1'b0, cmp_beat.count};
		for (int k = 0; k < num_words; k++) begin
			join_w[k] = (k < res_cnt) ? res_words[num_words-1-k] : '0;
			join_w[k+num_words] = '0;
		end
		// new words land right after the residue
		for (int c = 0; c < num_words; c++) begin
			if (c < cmp_beat.count) begin
				join_w[c + res_cnt] = cmp_beat.words[num_words-1-c];
			end
		end
		for (int k = 0; k < num_words; k++) begin
			lo_words[num_words-1-k] = join_w[k];
			hi_words[num_words-1-k] = join_w[k+num_words];
		end
	end

	assign full = (total >= 5'(num_words));

	// pg_a is the full page, or the remainder when the beat did not fill one
	// pg_b only exists when last follows a full page, its count may be zero
	always_comb begin
		pg_a.words = lo_words;
		pg_a.count = full ? count_t'(num_words) : count_t'(total);
		pg_a.last = cmp_beat.last && !full;
		pg_b.words = hi_words;
		pg_b.count = count_t'(total - 5'(num_words));
		pg_b.last = 1'b1;
		n_wr = '0;
		if (cmp_valid) begin
			n_wr = {1'b0, full} + {1'b0, cmp_beat.last};
		end
	end

	//////////////////////////////////////////////////
	// residue and page queue
	//////////////////////////////////////////////////

	always_ff @(posedge clk or posedge arst) begin
		if (arst) begin
			res_cnt <= '0;
			wr_ptr <= '0;
			rd_ptr <= '0;
			q_cnt <= '0;
			cr_ret <= '0;
		end else begin
			if (cmp_valid) begin
				if (cmp_beat.last) begin
					res_cnt <= '0;
				end else if (full) begin
					res_cnt <= count_t'(total - 5'(num_words));
				end else begin
					res_cnt <= count_t'(total);
				end
			end
			// each beat reserved two slots, hand back the ones it left unused
			cr_ret <= cmp_valid ? credit_t'(2'd2 - n_wr) : '0;
			wr_ptr <= qptr_t'(wr_ptr + n_wr);
			rd_ptr <= qptr_t'(rd_ptr + q_pop);
			q_cnt <= credit_t'(q_cnt + n_wr - q_pop);
		end
	end

	always_ff @(posedge clk) begin
		if (cmp_valid && !cmp_beat.last) begin
			res_words <= full ? hi_words : lo_words;
		end
		if (n_wr != 2'd0) begin
			mem[wr_ptr] <= pg_a;
		end
		if (n_wr == 2'd2) begin
			mem[qptr_t'(wr_ptr + 1'b1)] <= pg_b;
		end
	end

	assign q_valid = (q_cnt != '0);
	assign q_page = mem[rd_ptr];

	// credits upstream must keep room for both pages of a beat
	a_no_overflow: assert property (@(posedge clk) disable iff (arst)
		n_wr != 2'd0 |-> 4'(q_cnt) + 4'(n_wr) <= 4'(queue_depth));

	a_no_underflow: assert property (@(posedge clk) disable iff (arst)
		q_pop |-> q_cnt != '0);

endmodule

`default_nettype wire

/* design/page_sender.sv */
//////////////////////////////////////////////////
// four-phase master, next req waits for ack low
//////////////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module page_sender (
	input wire logic clk,
	input wire logic arst,
	input wire logic q_valid,
	input wire compact_pkg::page_t q_page,
	output logic q_pop,
	output logic out_req,
	input wire logic out_ack,
	output compact_pkg::page_t out_page,
	output logic pg_done
);

	import compact_pkg::*;

	typedef enum logic [1:0] {
		idle,
		req_high,
		wait_ack_low
	} state_t;

	state_t state;
	logic load;

	// head page is copied out so the queue entry stays until the sink has it
	assign load = (state == idle) && q_valid && !out_ack;

	always_ff @(posedge clk or posedge arst) begin
		if (arst) begin
			state <= idle;
			out_req <= 1'b0;
			q_pop <= 1'b0;
		end else begin
			q_pop <= 1'b0;
			case (state)
				idle: begin
					if (load) begin
						out_req <= 1'b1;
						state <= req_high;
					end
				end
				req_high: begin
					// sink has the page, free its queue slot
					if (out_ack) begin
						out_req <= 1'b0;
						q_pop <= 1'b1;
						state <= wait_ack_low;
					end
				end
				wait_ack_low: begin
					if (!out_ack) begin
						state <= idle;
					end
				end
				default: state <= idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (load) begin
			out_page <= q_page;
		end
	end

	// every delivered page frees one slot, which is one credit back
	assign pg_done = q_pop;

	a_page_stable: assert property (@(posedge clk) disable iff (arst)
		out_req && $past(out_req) |-> $stable(out_page));

endmodule

`default_nettype wire

/* design/compact_top.sv */
//////////////////////////////////////////////////
// sparse word packer, req/ack on both sides
//////////////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module compact_top (
	input wire logic clk,
	input wire logic arst,
	input wire logic in_req,
	input wire compact_pkg::beat_t in_beat,
	output logic in_ack,
	output logic out_req,
	input wire logic out_ack,
	output compact_pkg::page_t out_page
);

	import compact_pkg::*;

	logic cap_valid;
	beat_t cap_beat;
	logic cmp_valid;
	cbeat_t cmp_beat;
	logic q_valid;
	page_t q_page;
	logic q_pop;
	// credit return paths back to the capture stage
	credit_t cr_ret;
	logic pg_done;

	word_capture i_capture (
		.clk(clk),
		.arst(arst),
		.in_req(in_req),
		.in_beat(in_beat),
		.in_ack(in_ack),
		.cap_valid(cap_valid),
		.cap_beat(cap_beat),
		.cr_ret(cr_ret),
		.pg_done(pg_done)
	);

	word_compactor i_compactor (
		.clk(clk),
		.arst(arst),
		.cap_valid(cap_valid),
		.cap_beat(cap_beat),
		.cmp_valid(cmp_valid),
		.cmp_beat(cmp_beat)
	);

	page_accumulator i_accumulator (
		.clk(clk),
		.arst(arst),
		.cmp_valid(cmp_valid),
		.cmp_beat(cmp_beat),
		.q_valid(q_valid),
		.q_page(q_page),
		.q_pop(q_pop),
		.cr_ret(cr_ret)
	);

	page_sender i_sender (
		.clk(clk),
		.arst(arst),
		.q_valid(q_valid),
		.q_page(q_page),
		.q_pop(q_pop),
		.out_req(out_req),
		.out_ack(out_ack),
		.out_page(out_page),
		.pg_done(pg_done)
	);

endmodule

`default_nettype wire

/* test/tb_compact.sv */
//////////////////////////////////////////////////
// directed testbench for the sparse word packer
// expected pages come from a queue model of the packing rules
//////////////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module tb_compact;

	import compact_pkg::*;

	// beats over all tests, sizes the watchdog
	localparam int total_beats = 60;

	logic clk;
	logic arst;
	logic in_req;
	beat_t in_beat;
	logic in_ack;
	logic out_req;
	logic out_ack;
	page_t out_page;

	// model state, words waiting for a page and pages waiting for the sink
	word_t res_q[$];
	page_t exp_q[$];

	int val_errs = 0;
	int other_errs = 0;
	int ack_delay = 1;
	int held_off = 0;

	compact_top i_dut (
		.clk(clk),
		.arst(arst),
		.in_req(in_req),
		.in_beat(in_beat),
		.in_ack(in_ack),
		.out_req(out_req),
		.out_ack(out_ack),
		.out_page(out_page)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	//////////////////////////////////////////////////
	// compare tasks and reference model
	//////////////////////////////////////////////////

	task automatic check_word(input string name, input word_t got, input word_t exp);
		if (got !== exp) begin
			$display("ERR %s got %h expected %h", name, got, exp);
			val_errs++;
		end
	endtask

	task automatic check_count(input string name, input count_t got, input count_t exp);
		if (got !== exp) begin
			$display("ERR %s got %h expected %h", name, got, exp);
			val_errs++;
		end
	endtask

	task automatic check_last(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("ERR %s got %h expected %h", name, got, exp);
			val_errs++;
		end
	endtask

	// valid words are taken first word first, i.e. from the mask msb down
	task automatic model_beat(input beat_t b);
		page_t p;
		int n;
		for (int i = num_words - 1; i >= 0; i--) begin
			if (b.mask[i]) begin
				res_q.push_back(b.words[i]);
			end
		end
		// at most one full page per beat, since the residue stays below eight
		if (res_q.size() >= num_words) begin
			p = '0;
			for (int k = 0; k < num_words; k++) begin
				p.words[num_words-1-k] = res_q.pop_front();
			end
			p.count = count_t'(num_words);
			p.last = 1'b0;
			exp_q.push_back(p);
		end
		// the end of a packet always shows up as a page, even an empty one
		if (b.last) begin
			p = '0;
			n = res_q.size();
			for (int k = 0; k < n; k++) begin
				p.words[num_words-1-k] = res_q.pop_front();
			end
			p.count = count_t'(n);
			p.last = 1'b1;
			exp_q.push_back(p);
		end
		if (exp_q.size() > queue_depth) begin
			$display("more pages in flight than the page queue can hold");
			other_errs++;
		end
	endtask

	task automatic compare_page(input page_t got);
		page_t exp;
		if (exp_q.size() == 0) begin
			$display("a page arrived when no page was expected");
			other_errs++;
			return;
		end
		exp = exp_q.pop_front();
		check_count("out_page.count", got.count, exp.count);
		check_last("out_page.last", got.last, exp.last);
		// only words below the count carry data
		for (int k = 0; k < num_words; k++) begin
			if (k < exp.count) begin
				check_word($sformatf("out_page.words[%0d]", num_words - 1 - k),
					got.words[num_words-1-k], exp.words[num_words-1-k]);
			end
		end
	endtask

	//////////////////////////////////////////////////
	// handshake drivers
	//////////////////////////////////////////////////

	function automatic beat_t make_beat(input mask_t m, input logic last);
		beat_t b;
		for (int i = 0; i < num_words; i++) begin
			b.words[i] = word_t'({$urandom, $urandom});
		end
		b.mask = m;
		b.last = last;
		return b;
	endfunction

	// four-phase master side of the input, the model sees the beat once it is acked
	task automatic send_beat(input beat_t b);
		int waits;
		waits = 0;
		@(negedge clk);
		in_beat = b;
		in_req = 1'b1;
		while (!in_ack) begin
			@(negedge clk);
			waits++;
		end
		// one cycle is the normal answer, anything longer means no credits
		if (waits > 1) begin
			held_off++;
		end
		model_beat(b);
		in_req = 1'b0;
		while (in_ack) begin
			@(negedge clk);
		end
	endtask

	// sink side, compares each page as req rises and acks after ack_delay cycles
	initial begin
		forever begin
			@(negedge clk);
			if (out_req && !out_ack) begin
				compare_page(out_page);
				repeat (ack_delay) @(negedge clk);
				out_ack = 1'b1;
				while (out_req) begin
					@(negedge clk);
				end
				out_ack = 1'b0;
			end
		end
	end

	task automatic wait_drained();
		while (exp_q.size() != 0 || out_req || out_ack) begin
			@(negedge clk);
		end
	endtask

	//////////////////////////////////////////////////
	// directed tests
	//////////////////////////////////////////////////

	// four full beats in one packet, 32 words end with an empty last page
	task automatic test_full_beats();
		for (int i = 0; i < 4; i++) begin
			send_beat(make_beat(8'hFF, i == 3));
		end
		wait_drained();
	endtask

	task automatic test_sparse_single();
		mask_t masks [6] = '{8'hA5, 8'h01, 8'h80, 8'h3C, 8'hFF, 8'h00};
		for (int i = 0; i < 6; i++) begin
			send_beat(make_beat(masks[i], 1'b1));
		end
		wait_drained();
	endtask

	// 20 words give two full pages and a remainder of four
	task automatic test_sparse_packet();
		mask_t masks [5] = '{8'hA5, 8'h7E, 8'h11, 8'hF3, 8'h06};
		for (int i = 0; i < 5; i++) begin
			send_beat(make_beat(masks[i], i == 4));
		end
		wait_drained();
	endtask

	// one packet closed by an empty beat, one whose total is exactly eight
	task automatic test_packet_ends();
		send_beat(make_beat(8'hF0, 1'b0));
		send_beat(make_beat(8'h0F, 1'b0));
		send_beat(make_beat(8'h00, 1'b1));
		send_beat(make_beat(8'hCC, 1'b0));
		send_beat(make_beat(8'h33, 1'b1));
		wait_drained();
	endtask

	task automatic test_back_pressure();
		int held_before;
		held_before = held_off;
		ack_delay = 16;
		for (int i = 0; i < 40; i++) begin
			send_beat(make_beat(mask_t'($urandom), (($urandom % 4) == 0) || (i == 39)));
		end
		wait_drained();
		ack_delay = 1;
		if (held_off == held_before) begin
			$display("in_ack was never held off while the sink stalled");
			other_errs++;
		end
	endtask

	initial begin
		void'($urandom(32'h5771_81b2));
		arst = 1'b1;
		in_req = 1'b0;
		in_beat = '0;
		out_ack = 1'b0;
		repeat (16) @(posedge clk);
		@(negedge clk);
		arst = 1'b0;
		if (in_ack || out_req) begin
			$display("handshake outputs were not low after reset");
			other_errs++;
		end
		test_full_beats();
		test_sparse_single();
		test_sparse_packet();
		test_packet_ends();
		test_back_pressure();
		$display("errors: %0d value mismatches, %0d other failures", val_errs, other_errs);
		if (val_errs == 0 && other_errs == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

	// watchdog, about 400 ns per beat plus a margin for reset and draining
	initial begin
		#(total_beats * 400 + 10000);
		$display("the run timed out with %0d pages still expected", exp_q.size());
		$display("tests failed");
		$finish;
	end

endmodule

`default_nettype wire

/* verilog.f */
design/compact_pkg.sv
design/word_capture.sv
design/word_compactor.sv
design/page_accumulator.sv
design/page_sender.sv
design/compact_top.sv
test/tb_compact.sv
